// File: filelist.f
common/divsqrt_pkg.sv
divsqrt/divsqrt_fsm.sv
divsqrt/iter_counter.sv
divsqrt/divsqrt_lane.sv
verilog/operand_slicer.sv
verilog/result_packer.sv
verilog/divsqrt_multifmt_slice.sv
testbench/tb_divsqrt_slice.sv

// File: Bender.yml
package:
  name: divsqrt_multifmt_slice

sources:
  - files:
      - common/divsqrt_pkg.sv
      - divsqrt/divsqrt_fsm.sv
      - divsqrt/iter_counter.sv
      - divsqrt/divsqrt_lane.sv
      - verilog/operand_slicer.sv
      - verilog/result_packer.sv
      - verilog/divsqrt_multifmt_slice.sv
  - target: test
    files:
      - testbench/tb_divsqrt_slice.sv

// File: testbench/tb_divsqrt_slice.sv
// Directed testbench that checks the divide/sqrt slice and runs as the simulation top
module tb_divsqrt_slice import divsqrt_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [15:0] LFSR_SEED = 16'd49;
  localparam int unsigned OP_SLACK = 4;  // Handshake cycles around each operation
  localparam int unsigned TEST_CYCLES = 6 * (32 + OP_SLACK) + 7 * (8 + OP_SLACK)
                                        + 10 + (4 + OP_SLACK) + 6 + 40;
  localparam int unsigned TIMEOUT_CYCLES = 3 + 2 * TEST_CYCLES;

  logic clk_i = 1'b0;
  logic reset_i;
  logic [31:0] operands_a_i, operands_b_i, result_o;
  op_e op_i;
  fmt_e fmt_i;
  logic vectorial_op_i, in_valid_i, in_ready_o, flush_i, out_valid_o, out_ready_i, busy_o;
  logic [3:0] tag_i, tag_o;
  status_t status_o;

  logic [15:0] lfsr_q;
  int unsigned cycle_count = 0;
  int unsigned num_checks = 0;
  int unsigned num_errors = 0;
  int unsigned test_errors;
  int unsigned num_tests = 0;
  string cur_test;

  divsqrt_multifmt_slice #(.TagType(logic [3:0])) dut (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  // Taps 16, 14, 13, 11
  function automatic logic lfsr_next_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_next_bit = lfsr_q[15];
    lfsr_q = {lfsr_q[14:0], fb};
  endfunction

  function automatic logic [31:0] random_bits(input int unsigned n);
    logic [31:0] value;
    value = '0;
    for (int unsigned i = 0; i < n; i++) value = {value[30:0], lfsr_next_bit()};
    return value;
  endfunction

  task automatic tick();
    @(posedge clk_i);
    #1;  // Inputs change away from the edge
  endtask

  task automatic check(input logic ok, input string msg);
    num_checks++;
    assert (ok) else begin
      num_errors++;
      test_errors++;
      $display("error at %0t ns: %s: %s", $time, cur_test, msg);
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_errors = 0;
    num_tests++;
  endtask

  task automatic finish_test();
    if (test_errors == 0) $display("%s: ok", cur_test);
    else $display("%s: %0d errors", cur_test, test_errors);
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic logic [31:0] floor_sqrt(input logic [31:0] x, input int root_bits);
    logic [63:0] r, cand;
    r = '0;
    for (int i = root_bits - 1; i >= 0; i--) begin
      cand = r | (64'd1 << i);
      if (cand * cand <= {32'd0, x}) r = cand;
    end
    return r[31:0];
  endfunction

  task automatic model_op(input op_e op, input logic [31:0] a, input logic [31:0] b,
                          input int unsigned ew, input int unsigned n_elem,
                          output logic [31:0] exp_res, output status_t exp_st);
    logic [31:0] mask, ea, eb, q;
    exp_res = '0;
    exp_st = '0;
    mask = (ew == 32) ? 32'hFFFF_FFFF : (32'd1 << ew) - 1;
    for (int unsigned i = 0; i < n_elem; i++) begin
      ea = (a >> (i * ew)) & mask;
      eb = (b >> (i * ew)) & mask;
      if (op == SQRT) begin
        q = floor_sqrt(ea, ew / 2);
        if (q * q != ea) exp_st.nx = 1'b1;
      end else if (eb == '0) begin
        q = mask;  // Zero divisor flags dz only
        exp_st.dz = 1'b1;
      end else begin
        q = ea / eb;
        if (ea % eb != '0) exp_st.nx = 1'b1;
      end
      exp_res |= (q & mask) << (i * ew);
    end
  endtask

  // ----------------------------------------
  // Operation driver
  // ----------------------------------------
  task automatic send_op(input op_e op, input fmt_e fmt, input logic vec,
                         input logic [31:0] a, input logic [31:0] b, input logic [3:0] tag);
    while (!in_ready_o) tick();
    op_i = op;
    fmt_i = fmt;
    vectorial_op_i = vec;
    operands_a_i = a;
    operands_b_i = b;
    tag_i = tag;
    in_valid_i = 1'b1;
    tick();  // Accept edge
    in_valid_i = 1'b0;
    operands_a_i = ~a;  // Garbage after accept
    operands_b_i = ~b;
    tag_i = ~tag;
  endtask

  task automatic run_op(input op_e op, input fmt_e fmt, input logic vec,
                        input logic [31:0] a, input logic [31:0] b, input logic [3:0] tag,
                        input int unsigned ew, input int unsigned stall);
    logic [31:0] exp_res, held_res;
    status_t exp_st, held_st;
    int unsigned lat, exp_lat;
    exp_lat = (op == SQRT) ? ew / 2 : ew;
    model_op(op, a, b, ew, vec ? 32 / ew : 1, exp_res, exp_st);
    out_ready_i = (stall == 0);
    send_op(op, fmt, vec, a, b, tag);
    lat = 0;
    do begin
      tick();
      lat++;
    end while (!out_valid_o);
    check(lat == exp_lat, $sformatf("latency %0d, expected %0d", lat, exp_lat));
    check(result_o == exp_res, $sformatf("result %h, expected %h", result_o, exp_res));
    check(status_o == exp_st, $sformatf("status %b, expected %b", status_o, exp_st));
    check(tag_o == tag, $sformatf("tag %h, expected %h", tag_o, tag));
    held_res = result_o;
    held_st = status_o;
    in_valid_i = (stall != 0);  // A new operation is offered and must wait
    repeat (stall) begin
      tick();
      check(out_valid_o && !in_ready_o, "handshake changed while out_ready_i was low");
      check(result_o == held_res && status_o == held_st && tag_o == tag,
            "output changed while out_ready_i was low");
    end
    in_valid_i = 1'b0;
    out_ready_i = 1'b1;
    tick();  // Output transfer edge
    check(!out_valid_o && in_ready_o, "slice did not return to idle after the transfer");
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_reset_state();
    start_test("reset_state");
    check(in_ready_o && !out_valid_o && !busy_o, "wrong handshake state after reset");
    finish_test();
  endtask

  task automatic test_int32_div();
    logic [31:0] b;
    start_test("int32_div");
    for (int i = 0; i < 4; i++) begin
      b = random_bits(16);
      if (b == '0) b = 32'd1;
      run_op(DIV, INT32, 1'b0, random_bits(32), b, 4'(random_bits(4)), 32, 0);
    end
    run_op(DIV, INT32, 1'b0, 32'h0000_0090, 32'd12, 4'h3, 32, 0);  // Exact quotient
    finish_test();
  endtask

  task automatic test_int8_div_vec();
    logic [31:0] b;
    start_test("int8_div_vec");
    run_op(DIV, INT8, 1'b1, {8'd200, 8'd7, 8'd15, 8'd100}, {8'd7, 8'd0, 8'd3, 8'd10},
           4'h6, 8, 0);
    b = random_bits(32) | 32'h0101_0101;
    b[23:16] = 8'h00;
    run_op(DIV, INT8, 1'b1, random_bits(32), b, 4'h9, 8, 0);
    finish_test();
  endtask

  task automatic test_int16_sqrt();
    start_test("int16_sqrt");
    run_op(SQRT, INT16, 1'b0, 32'hABCD_03E8, 32'h1357_2468, 4'h1, 16, 0);  // 1000
    run_op(SQRT, INT16, 1'b0, 32'h55AA_3840, 32'h0, 4'h2, 16, 0);  // 14400 is a square
    finish_test();
  endtask

  task automatic test_int16_sqrt_vec();
    start_test("int16_sqrt_vec");
    run_op(SQRT, INT16, 1'b1, 32'hFFFF_0090, 32'h0, 4'hC, 16, 0);
    run_op(SQRT, INT16, 1'b1, random_bits(32), random_bits(32), 4'hD, 16, 0);
    finish_test();
  endtask

  task automatic test_backpressure();
    start_test("backpressure");
    run_op(DIV, INT32, 1'b0, random_bits(32), random_bits(12) | 32'd1, 4'hE, 32, 10);
    run_op(SQRT, INT8, 1'b1, random_bits(32), random_bits(32), 4'h7, 8, 0);
    finish_test();
  endtask

  task automatic test_flush();
    logic seen;
    start_test("flush");
    out_ready_i = 1'b1;
    send_op(DIV, INT32, 1'b0, 32'hFFFF_FFFF, 32'd3, 4'hA);
    repeat (5) tick();
    check(busy_o, "busy_o low during an operation");
    flush_i = 1'b1;
    tick();
    flush_i = 1'b0;
    check(!busy_o && !out_valid_o, "slice still busy after flush");
    seen = 1'b0;
    repeat (40) begin
      tick();
      seen |= out_valid_o;
    end
    check(!seen, "out_valid_o rose for a flushed operation");
    run_op(DIV, INT8, 1'b0, 32'h1234_56C8, 32'hFFFF_FF07, 4'h5, 8, 0);  // 200 / 7
    finish_test();
  endtask

  initial begin
    lfsr_q = LFSR_SEED;
    reset_i = 1'b1;
    operands_a_i = '0;
    operands_b_i = '0;
    op_i = DIV;
    fmt_i = INT32;
    vectorial_op_i = 1'b0;
    tag_i = '0;
    in_valid_i = 1'b0;
    flush_i = 1'b0;
    out_ready_i = 1'b1;
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    test_reset_state();
    test_int32_div();
    test_int8_div_vec();
    test_int16_sqrt();
    test_int16_sqrt_vec();
    test_backpressure();
    test_flush();

    $display("tests: %0d, checks: %0d, errors: %0d", num_tests, num_checks, num_errors);
    if (num_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/divsqrt_multifmt_slice.sv
// Top of the multi-format divide/sqrt slice: one shared FSM and counter driving four lanes
module divsqrt_multifmt_slice import divsqrt_pkg::*; #(
  parameter type TagType = logic
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic [WIDTH-1:0] operands_a_i,
  input  logic [WIDTH-1:0] operands_b_i,
  input  op_e              op_i,
  input  fmt_e             fmt_i,
  input  logic             vectorial_op_i,
  input  TagType           tag_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  logic             flush_i,
  output logic [WIDTH-1:0] result_o,
  output status_t          status_o,
  output TagType           tag_o,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic             busy_o
);

  logic [NUM_LANES-1:0][WIDTH-1:0] lane_a, lane_b, lane_result;
  logic [NUM_LANES-1:0]            lane_active;
  status_t [NUM_LANES-1:0]         lane_status;
  logic                            start, step, last_step;
  fmt_e                            fmt_q;
  logic                            vector_q;

  operand_slicer i_slicer (
    .operands_a_i   ( operands_a_i   ),
    .operands_b_i   ( operands_b_i   ),
    .fmt_i          ( fmt_i          ),
    .vectorial_op_i ( vectorial_op_i ),
    .lane_a_o       ( lane_a         ),
    .lane_b_o       ( lane_b         ),
    .lane_active_o  ( lane_active    )
  );

  divsqrt_fsm #(.TagType(TagType)) i_fsm (
    .clk_i, .reset_i, .in_valid_i, .out_ready_i, .flush_i,
    .last_step_i    ( last_step      ),
    .fmt_i, .vectorial_op_i, .tag_i, .in_ready_o, .out_valid_o, .busy_o,
    .start_o        ( start          ),
    .step_o         ( step           ),
    .fmt_q_o        ( fmt_q          ),
    .vector_q_o     ( vector_q       ),
    .tag_o
  );

  iter_counter i_counter (
    .clk_i, .reset_i,
    .start_i     ( start     ),
    .step_i      ( step      ),
    .op_i, .fmt_i,
    .last_step_o ( last_step )
  );

  // ----------------------------------------
  // Lanes, each sized for its widest element
  // ----------------------------------------
  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_lanes
    localparam int unsigned LW = lane_width(lane);
    logic [LW-1:0] local_result;

    divsqrt_lane #(.LaneWidth(LW)) i_lane (
      .clk_i, .reset_i,
      .start_i       ( start                ),
      .step_i        ( step                 ),
      .lane_active_i ( lane_active[lane]    ),
      .op_i, .fmt_i,
      .operand_a_i   ( lane_a[lane][LW-1:0] ),
      .operand_b_i   ( lane_b[lane][LW-1:0] ),
      .result_o      ( local_result         ),
      .status_o      ( lane_status[lane]    )
    );

    assign lane_result[lane] = WIDTH'(local_result);  // Zero-extend narrow lanes
  end

  result_packer i_packer (
    .lane_result_i ( lane_result ),
    .lane_status_i ( lane_status ),
    .fmt_i         ( fmt_q       ),
    .vector_i      ( vector_q    ),
    .result_o, .status_o
  );

endmodule

// File: verilog/result_packer.sv
// Packs the lane results back into one word by format and collapses the lane status flags
module result_packer import divsqrt_pkg::*; (
  input  logic [NUM_LANES-1:0][WIDTH-1:0] lane_result_i,
  input  status_t [NUM_LANES-1:0]         lane_status_i,
  input  fmt_e                            fmt_i,
  input  logic                            vector_i,
  output logic [WIDTH-1:0]                result_o,
  output status_t                         status_o
);

  logic [WIDTH-1:0]     elem_mask;
  logic [NUM_LANES-1:0] lane_used;

  assign elem_mask = {WIDTH{1'b1}} >> (WIDTH - fmt_width(fmt_i));

  always_comb begin : used_lanes
    for (int unsigned lane = 0; lane < NUM_LANES; lane++) begin
      lane_used[lane] = (lane == 0) || (vector_i && (lane < fmt_lanes(fmt_i)));
    end
  end

  // ----------------------------------------
  // Result word
  // ----------------------------------------
  // Bits no used lane covers stay zero
  always_comb begin : pack
    result_o = '0;
    for (int unsigned lane = 0; lane < NUM_LANES; lane++) begin
      if (lane_used[lane]) begin
        result_o |= (lane_result_i[lane] & elem_mask) << (lane * fmt_width(fmt_i));
      end
    end
  end

  // Collapse the status
  always_comb begin : collapse
    status_o = '0;
    for (int unsigned lane = 0; lane < NUM_LANES; lane++) begin
      status_o |= lane_status_i[lane];  // Idle lanes report zero
    end
  end

endmodule

// File: verilog/operand_slicer.sv
// Splits the operand words into per-lane elements by format and marks the lanes in use
module operand_slicer import divsqrt_pkg::*; (
  input  logic [WIDTH-1:0]                 operands_a_i,
  input  logic [WIDTH-1:0]                 operands_b_i,
  input  fmt_e                             fmt_i,
  input  logic                             vectorial_op_i,
  output logic [NUM_LANES-1:0][WIDTH-1:0]  lane_a_o,
  output logic [NUM_LANES-1:0][WIDTH-1:0]  lane_b_o,
  output logic [NUM_LANES-1:0]             lane_active_o
);

  // ----------------------------------------
  // Per-lane slicing
  // ----------------------------------------
  always_comb begin : slice
    for (int unsigned lane = 0; lane < NUM_LANES; lane++) begin
      // Upper bits are dropped inside the lane
      lane_a_o[lane] = operands_a_i >> (lane * fmt_width(fmt_i));
      lane_b_o[lane] = operands_b_i >> (lane * fmt_width(fmt_i));
    end
  end

  // Scalar ops use lane 0 only
  always_comb begin : activity
    for (int unsigned lane = 0; lane < NUM_LANES; lane++) begin
      if (lane == 0) begin
        lane_active_o[lane] = 1'b1;
      end else begin
        lane_active_o[lane] = vectorial_op_i && (lane < fmt_lanes(fmt_i));
      end
    end
  end

endmodule

// File: divsqrt/divsqrt_lane.sv
// One vector lane: iterative restoring unsigned divide or floor square root, stepped by the FSM
module divsqrt_lane import divsqrt_pkg::*; #(
  parameter int unsigned LaneWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 start_i,
  input  logic                 step_i,
  input  logic                 lane_active_i,
  input  op_e                  op_i,
  input  fmt_e                 fmt_i,
  input  logic [LaneWidth-1:0] operand_a_i,
  input  logic [LaneWidth-1:0] operand_b_i,
  output logic [LaneWidth-1:0] result_o,
  output status_t              status_o
);

  logic                 active_q;
  op_e                  op_q;
  fmt_e                 fmt_q;
  logic                 dz_q;
  logic [LaneWidth-1:0] a_q;     // Dividend or radicand, consumed from the top
  logic [LaneWidth-1:0] b_q;     // Divisor
  logic [LaneWidth-1:0] quot_q;  // Quotient or root
  logic [LaneWidth-1:0] rem_q;

  logic [1:0]           top_bits;
  logic [LaneWidth+1:0] shifted, trial, diff;
  logic                 fits;

  // Element width, capped at what this lane can hold
  function automatic int unsigned eff_width(fmt_e fmt);
    return (fmt_width(fmt) > LaneWidth) ? LaneWidth : fmt_width(fmt);
  endfunction

  function automatic logic [LaneWidth-1:0] width_mask(fmt_e fmt);
    return {LaneWidth{1'b1}} >> (LaneWidth - eff_width(fmt));
  endfunction

  // ----------------------------------------
  // One restoring iteration
  // ----------------------------------------
  always_comb begin : iteration
    top_bits = 2'(a_q >> (eff_width(fmt_q) - 2));  // Next unconsumed bits of the element
    if (op_q == SQRT) begin
      shifted = {rem_q, top_bits};
      trial   = {quot_q, 2'b01};  // 4*root + 1
    end else begin
      shifted = {1'b0, rem_q, top_bits[1]};
      trial   = {2'b00, b_q};
    end
    diff = shifted - trial;
    fits = (shifted >= trial);
  end

  always_ff @(posedge clk_i) begin : active_reg
    if (reset_i) begin
      active_q <= 1'b0;
    end else if (start_i) begin
      active_q <= lane_active_i;
    end
  end

  always_ff @(posedge clk_i) begin : datapath
    if (start_i) begin
      a_q    <= operand_a_i & width_mask(fmt_i);
      b_q    <= operand_b_i & width_mask(fmt_i);
      quot_q <= '0;
      rem_q  <= '0;
      op_q   <= op_i;
      fmt_q  <= fmt_i;
      dz_q   <= (op_i == DIV) && ((operand_b_i & width_mask(fmt_i)) == '0);
    end else if (step_i && active_q) begin
      a_q    <= (op_q == SQRT) ? (a_q << 2) : (a_q << 1);
      rem_q  <= fits ? diff[LaneWidth-1:0] : shifted[LaneWidth-1:0];
      quot_q <= {quot_q[LaneWidth-2:0], fits};  // Zero divisor always fits, all ones
    end
  end

  // Divide by zero reports dz alone
  assign result_o = active_q ? quot_q : '0;
  assign status_o = active_q ? status_t'{dz: dz_q, nx: (|rem_q) && !dz_q} : '0;

endmodule

// File: divsqrt/iter_counter.sv
// Shared iteration counter, loaded per operation and format, flags the final lane step
module iter_counter import divsqrt_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  input  logic start_i,
  input  logic step_i,
  input  op_e  op_i,
  input  fmt_e fmt_i,
  output logic last_step_o
);

  logic [CNT_BITS-1:0] cnt_q;
  logic [CNT_BITS-1:0] num_steps;

  // One bit per step for divide, one bit pair per step for square root
  always_comb begin : step_count
    if (op_i == SQRT) begin
      num_steps = CNT_BITS'(fmt_width(fmt_i) / 2);
    end else begin
      num_steps = CNT_BITS'(fmt_width(fmt_i));
    end
  end

  always_ff @(posedge clk_i) begin : count_reg
    if (reset_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= num_steps;
    end else if (step_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign last_step_o = step_i && (cnt_q == CNT_BITS'(1));

  // Steps must stop once the loaded count is used up
  a_step_in_range : assert property (@(posedge clk_i) disable iff (reset_i)
    step_i |-> (cnt_q != '0));

endmodule

// File: divsqrt/divsqrt_fsm.sv
// Control FSM shared by all lanes that accepts one operation, steps it and holds the result
module divsqrt_fsm import divsqrt_pkg::*; #(
  parameter type TagType = logic
) (
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   in_valid_i,
  input  logic   out_ready_i,
  input  logic   flush_i,
  input  logic   last_step_i,
  input  fmt_e   fmt_i,
  input  logic   vectorial_op_i,
  input  TagType tag_i,
  output logic   in_ready_o,
  output logic   out_valid_o,
  output logic   busy_o,
  output logic   start_o,
  output logic   step_o,
  output fmt_e   fmt_q_o,
  output logic   vector_q_o,
  output TagType tag_o
);

  typedef enum logic [1:0] {IDLE, CALC, DONE} state_e;

  state_e state_q, state_d;

  assign in_ready_o  = (state_q == IDLE) && !flush_i;  // No accept while flushing
  assign start_o     = in_valid_i && in_ready_o;
  assign step_o      = (state_q == CALC);
  assign out_valid_o = (state_q == DONE);
  assign busy_o      = (state_q != IDLE);

  always_comb begin : next_state
    state_d = state_q;
    case (state_q)
      IDLE: if (start_o) state_d = CALC;
      CALC: if (last_step_i) state_d = DONE;
      DONE: if (out_ready_i) state_d = IDLE;  // Held until downstream takes it
      default: state_d = IDLE;
    endcase
    if (flush_i) state_d = IDLE;  // Flush wins from any state
  end

  always_ff @(posedge clk_i) begin : state_reg
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Operation info travels alongside the lanes
  always_ff @(posedge clk_i) begin : info_reg
    if (start_o) begin
      fmt_q_o    <= fmt_i;
      vector_q_o <= vectorial_op_i;
      tag_o      <= tag_i;
    end
  end

  // The counter may only end an operation that is iterating
  a_last_step_in_calc : assert property (@(posedge clk_i) disable iff (reset_i)
    last_step_i |-> step_o);

endmodule

// File: common/divsqrt_pkg.sv
// Shared widths, format/operation types, status struct and helpers for the divide/sqrt slice
package divsqrt_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int unsigned WIDTH     = 32;  // Operand and result word
  localparam int unsigned NUM_LANES = 4;
  localparam int unsigned FMT_BITS  = 2;
  localparam int unsigned CNT_BITS  = 6;   // Holds up to 32 iterations

  typedef enum logic [FMT_BITS-1:0] {
    INT8  = 2'd0,
    INT16 = 2'd1,
    INT32 = 2'd2
  } fmt_e;

  typedef enum logic {
    DIV  = 1'b0,
    SQRT = 1'b1
  } op_e;

  typedef struct packed {
    logic dz;  // Divide by zero
    logic nx;  // Inexact, nonzero remainder
  } status_t;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic int unsigned fmt_width(fmt_e fmt);
    case (fmt)
      INT8:    return 8;
      INT16:   return 16;
      default: return 32;
    endcase
  endfunction

  // Widest element a lane ever has to hold
  function automatic int unsigned lane_width(int unsigned lane);
    case (lane)
      0:       return 32;
      1:       return 16;
      default: return 8;
    endcase
  endfunction

  function automatic int unsigned fmt_lanes(fmt_e fmt);
    case (fmt)
      INT8:    return 4;
      INT16:   return 2;
      default: return 1;
    endcase
  endfunction

endpackage
